// ==== dmaPkg.sv ====
`default_nettype none

package dmaPkg;

  localparam int busWidth       = 32;
  localparam int memAddrWidth   = 9;
  localparam int blockSizeWidth = 10;
  localparam int burstLenWidth  = 8;
  localparam int ciIdWidth      = 8;

  typedef logic [busWidth-1:0]       busWord;
  typedef logic [memAddrWidth-1:0]   memAddr;
  typedef logic [blockSizeWidth-1:0] blockSize;
  typedef logic [burstLenWidth-1:0]  burstLen;   // words minus one
  typedef logic [ciIdWidth-1:0]      ciId;
  typedef logic [3:0]                ciCommand;  // valueA[12:9]
  typedef logic [2:0]                ciSelect;   // valueA[12:10]

  // write commands, bit 0 is the write flag
  localparam ciCommand cmdSetBusAddr   = 4'd3;
  localparam ciCommand cmdSetMemAddr   = 4'd5;
  localparam ciCommand cmdSetBlockSize = 4'd7;
  localparam ciCommand cmdSetBurstSize = 4'd9;
  localparam ciCommand cmdStartDma     = 4'd11;

  // read-back selectors
  localparam ciSelect selBusAddr   = 3'd1;
  localparam ciSelect selMemAddr   = 3'd2;
  localparam ciSelect selBlockSize = 3'd3;
  localparam ciSelect selBurstSize = 3'd4;
  localparam ciSelect selStatus    = 3'd5;

  typedef enum logic [3:0] {
    idle, init, requestBus, setUpTransaction, doRead,
    waitEnd, doWrite, endTransactionError, endWriteTransaction
  } dmaState;

endpackage

`default_nettype wire

// ==== dualPortRam.sv ====
`timescale 1ns/1ns
`default_nettype none

// simple dual-port word memory, one clock
module dualPortRam #(
  parameter int memWords = 512
) (
  input  wire logic           clock,
  input  wire logic           writeEnable,
  input  wire dmaPkg::memAddr writeAddress,
  input  wire dmaPkg::busWord writeData,
  input  wire dmaPkg::memAddr readAddress,
  output dmaPkg::busWord      readData
);

  dmaPkg::busWord mem [memWords];

  always_ff @(posedge clock)
  begin
    if (writeEnable)
      mem[writeAddress] <= writeData;
    readData <= mem[readAddress];  // one cycle latency
  end

endmodule

`default_nettype wire

// ==== ciRegisters.sv ====
`timescale 1ns/1ns
`default_nettype none

module ciRegisters #(
  parameter dmaPkg::ciId customIdDma = 8'd0
) (
  input  wire logic             clock,
  input  wire logic             rstN,
  input  wire logic             start,
  input  wire dmaPkg::ciId      ciN,
  input  wire dmaPkg::busWord   valueA,
  input  wire dmaPkg::busWord   valueB,
  input  wire logic             dmaBusy,
  input  wire logic             busError,
  output logic                  done,
  output dmaPkg::busWord        result,
  output dmaPkg::busWord        busStartAddr,
  output dmaPkg::memAddr        memStartAddr,
  output dmaPkg::blockSize      blockWords,
  output dmaPkg::burstLen       burstSize,
  output logic                  requestDmaIn,
  output logic                  requestDmaOut
);

  logic             isMyCi;
  logic             isWrite;
  logic             isRead;
  logic             readDoneReg;
  dmaPkg::ciCommand command;
  dmaPkg::ciSelect  selectReg;
  dmaPkg::busWord   selectedWord;

  assign isMyCi  = start && (ciN == customIdDma);
  assign command = valueA[12:9];
  assign isWrite = isMyCi && valueA[9];
  assign isRead  = isMyCi && !valueA[9];

  // writes finish at once, reads one cycle later
  assign done = isWrite || readDoneReg;

  // start only honored while the engine is idle
  assign requestDmaIn  = isWrite && (command == dmaPkg::cmdStartDma) && !dmaBusy &&
                         valueB[0] && !valueB[1];
  assign requestDmaOut = isWrite && (command == dmaPkg::cmdStartDma) && !dmaBusy &&
                         !valueB[0] && valueB[1];

  always_ff @(posedge clock)
  begin
    if (!rstN)
    begin
      busStartAddr <= '0;
      memStartAddr <= '0;
      blockWords   <= '0;
      burstSize    <= '0;
      readDoneReg  <= 1'b0;
    end
    else
    begin
      readDoneReg <= isRead;
      if (isWrite)
      begin
        case (command)
          dmaPkg::cmdSetBusAddr:   busStartAddr <= valueB;
          dmaPkg::cmdSetMemAddr:   memStartAddr <= dmaPkg::memAddr'(valueB);
          dmaPkg::cmdSetBlockSize: blockWords   <= dmaPkg::blockSize'(valueB);
          dmaPkg::cmdSetBurstSize: burstSize    <= dmaPkg::burstLen'(valueB);
          default:                 ;
        endcase
      end
    end
  end

  // selector kept for the read-done cycle
  always_ff @(posedge clock)
  begin
    if (isRead)
      selectReg <= valueA[12:10];
  end

  always_comb
  begin
    case (selectReg)
      dmaPkg::selBusAddr:   selectedWord = busStartAddr;
      dmaPkg::selMemAddr:   selectedWord = dmaPkg::busWord'(memStartAddr);
      dmaPkg::selBlockSize: selectedWord = dmaPkg::busWord'(blockWords);
      dmaPkg::selBurstSize: selectedWord = dmaPkg::busWord'(burstSize);
      dmaPkg::selStatus:    selectedWord = {30'd0, busError, dmaBusy};
      default:              selectedWord = '0;
    endcase
  end

  assign result = readDoneReg ? selectedWord : '0;

endmodule

`default_nettype wire

// ==== dmaController.sv ====
`timescale 1ns/1ns
`default_nettype none

module dmaController #(
  parameter dmaPkg::busWord lineStride = 32'd640
) (
  input  wire logic             clock,
  input  wire logic             rstN,
  input  wire dmaPkg::busWord   busStartAddr,
  input  wire dmaPkg::memAddr   memStartAddr,
  input  wire dmaPkg::blockSize blockWords,
  input  wire dmaPkg::burstLen  burstSize,
  input  wire logic             requestDmaIn,
  input  wire logic             requestDmaOut,
  input  wire logic             transactionGranted,
  input  wire logic             busErrorIn,
  input  wire logic             busyIn,
  input  wire logic             endTransactionReg,
  input  wire logic             dataValidReg,
  input  wire dmaPkg::busWord   ramReadData,
  output logic                  dmaBusy,
  output logic                  busError,
  output logic                  ramWriteEnable,
  output dmaPkg::memAddr        ramAddress,
  output logic                  requestTransaction,
  output logic                  beginTransactionOut,
  output logic                  readNotWriteOut,
  output logic                  endTransactionOut,
  output logic                  dataValidOut,
  output logic [3:0]            byteEnablesOut,
  output dmaPkg::burstLen       burstSizeOut,
  output dmaPkg::busWord        addressDataOut
);

  dmaPkg::dmaState  stateReg;
  dmaPkg::dmaState  nextState;
  logic             isReadBurstReg;
  logic             busErrorReg;
  dmaPkg::busWord   busAddrShadow;
  dmaPkg::blockSize remainingWords;
  dmaPkg::memAddr   memAddrReg;
  logic [dmaPkg::burstLenWidth:0] wordsLeft;  // msb set once the burst is sent
  dmaPkg::blockSize maxBurst;
  dmaPkg::blockSize lastBurst;
  dmaPkg::burstLen  usedBurst;
  logic             dmaDone;
  logic             doBusWrite;
  logic             inDataPhase;

  assign dmaBusy     = (stateReg != dmaPkg::idle);
  assign busError    = busErrorReg;
  assign inDataPhase = (stateReg == dmaPkg::doRead) || (stateReg == dmaPkg::doWrite);

  // burst is the lesser of what remains and burstSize + 1
  assign maxBurst  = dmaPkg::blockSize'(burstSize) + 10'd1;
  assign lastBurst = remainingWords - 10'd1;
  assign usedBurst = (remainingWords > maxBurst) ? burstSize : dmaPkg::burstLen'(lastBurst);

  assign doBusWrite     = (stateReg == dmaPkg::doWrite) && !busyIn && !wordsLeft[8];
  assign ramWriteEnable = (stateReg == dmaPkg::doRead) && dataValidReg;

  // look-ahead so the registered read data follows memAddrReg
  assign ramAddress = doBusWrite ? memAddrReg + 9'd1 : memAddrReg;

  // last word may arrive together with the end of the transaction
  assign dmaDone = (remainingWords == 10'd0) ||
                   ((remainingWords == 10'd1) && endTransactionReg && dataValidReg);

  assign requestTransaction = (stateReg == dmaPkg::requestBus);

  always_comb
  begin
    nextState = stateReg;
    case (stateReg)
      dmaPkg::idle:
        if (requestDmaIn || requestDmaOut)
          nextState = dmaPkg::init;
      dmaPkg::init:
        nextState = (blockWords == 10'd0) ? dmaPkg::idle : dmaPkg::requestBus;
      dmaPkg::requestBus:
        if (transactionGranted)
          nextState = dmaPkg::setUpTransaction;
      dmaPkg::setUpTransaction:
        nextState = isReadBurstReg ? dmaPkg::doRead : dmaPkg::doWrite;
      dmaPkg::doRead:
        if (endTransactionReg)
          nextState = (dmaDone || busErrorIn) ? dmaPkg::idle : dmaPkg::requestBus;
        else if (busErrorIn)
          nextState = dmaPkg::waitEnd;  // slave still has to close the burst
      dmaPkg::waitEnd:
        if (endTransactionReg)
          nextState = dmaPkg::idle;
      dmaPkg::doWrite:
        if (busErrorIn)
          nextState = dmaPkg::endTransactionError;
        else if (wordsLeft[8] && !busyIn)
          nextState = dmaPkg::endWriteTransaction;
      dmaPkg::endWriteTransaction:
        nextState = dmaDone ? dmaPkg::idle : dmaPkg::requestBus;
      default:
        nextState = dmaPkg::idle;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (!rstN)
    begin
      stateReg    <= dmaPkg::idle;
      busErrorReg <= 1'b0;
    end
    else
    begin
      stateReg <= nextState;
      if (stateReg == dmaPkg::init)
        busErrorReg <= 1'b0;
      else if (inDataPhase && busErrorIn)
        busErrorReg <= 1'b1;
    end
  end

  // shadow counters, loaded at init
  always_ff @(posedge clock)
  begin
    if (stateReg == dmaPkg::idle)
      isReadBurstReg <= requestDmaIn;

    if (stateReg == dmaPkg::init)
    begin
      busAddrShadow  <= busStartAddr;
      remainingWords <= blockWords;
      memAddrReg     <= memStartAddr;
    end
    else
    begin
      if (((stateReg == dmaPkg::doRead) && endTransactionReg) ||
          (stateReg == dmaPkg::endWriteTransaction))
        busAddrShadow <= busAddrShadow + lineStride;  // next line
      if (ramWriteEnable || doBusWrite)
      begin
        remainingWords <= remainingWords - 10'd1;
        memAddrReg     <= memAddrReg + 9'd1;
      end
    end

    if (stateReg == dmaPkg::setUpTransaction)
      wordsLeft <= {1'b0, usedBurst};
    else if (doBusWrite)
      wordsLeft <= wordsLeft - 9'd1;
  end

  always_ff @(posedge clock)
  begin
    if (!rstN)
    begin
      beginTransactionOut <= 1'b0;
      readNotWriteOut     <= 1'b0;
      byteEnablesOut      <= 4'h0;
      burstSizeOut        <= '0;
      endTransactionOut   <= 1'b0;
      dataValidOut        <= 1'b0;
    end
    else
    begin
      beginTransactionOut <= (stateReg == dmaPkg::setUpTransaction);
      readNotWriteOut     <= (stateReg == dmaPkg::setUpTransaction) && isReadBurstReg;
      byteEnablesOut      <= (stateReg == dmaPkg::setUpTransaction) ? 4'hF : 4'h0;
      burstSizeOut        <= (stateReg == dmaPkg::setUpTransaction) ? usedBurst : '0;
      endTransactionOut   <= (stateReg == dmaPkg::endTransactionError) ||
                             (stateReg == dmaPkg::endWriteTransaction);
      if (!((stateReg == dmaPkg::doWrite) && busyIn))
        dataValidOut <= doBusWrite;  // held while the slave is busy
    end
  end

  always_ff @(posedge clock)
  begin
    if ((stateReg == dmaPkg::doWrite) && busyIn)
      addressDataOut <= addressDataOut;
    else if (doBusWrite)
      addressDataOut <= ramReadData;
    else if (stateReg == dmaPkg::setUpTransaction)
      addressDataOut <= {busAddrShadow[31:2], 2'b00};  // word aligned
    else
      addressDataOut <= '0;
  end

endmodule

`default_nettype wire

// ==== ramDmaCi.sv ====
`timescale 1ns/1ns
`default_nettype none

module ramDmaCi #(
  parameter dmaPkg::ciId    customIdDma = 8'd0,
  parameter dmaPkg::busWord lineStride  = 32'd640,
  parameter int             memWords    = 512
) (
  input  wire logic           clock,
  input  wire logic           rstN,
  input  wire logic           start,
  input  wire dmaPkg::ciId    ciN,
  input  wire dmaPkg::busWord valueA,
  input  wire dmaPkg::busWord valueB,
  output logic                done,
  output dmaPkg::busWord      result,
  output logic                requestTransaction,
  input  wire logic           transactionGranted,
  input  wire logic           endTransactionIn,
  input  wire logic           dataValidIn,
  input  wire logic           busErrorIn,
  input  wire logic           busyIn,
  input  wire dmaPkg::busWord addressDataIn,
  output logic                beginTransactionOut,
  output logic                readNotWriteOut,
  output logic                endTransactionOut,
  output logic                dataValidOut,
  output logic [3:0]          byteEnablesOut,
  output dmaPkg::burstLen     burstSizeOut,
  output dmaPkg::busWord      addressDataOut
);

  dmaPkg::busWord   busStartAddr;
  dmaPkg::memAddr   memStartAddr;
  dmaPkg::blockSize blockWords;
  dmaPkg::burstLen  burstSize;
  logic             requestDmaIn;
  logic             requestDmaOut;
  logic             dmaBusy;
  logic             busError;
  logic             ramWriteEnable;
  dmaPkg::memAddr   ramAddress;
  dmaPkg::busWord   ramReadData;
  logic             endTransactionReg;
  logic             dataValidReg;
  dmaPkg::busWord   addressDataReg;

  // bus input stage
  always_ff @(posedge clock)
  begin
    if (!rstN)
    begin
      endTransactionReg <= 1'b0;
      dataValidReg      <= 1'b0;
    end
    else
    begin
      endTransactionReg <= endTransactionIn;
      dataValidReg      <= dataValidIn;
    end
    addressDataReg <= addressDataIn;
  end

  ciRegisters #(.customIdDma(customIdDma)) ciRegisters_i (
    .clock, .rstN, .start, .ciN, .valueA, .valueB,
    .dmaBusy, .busError, .done, .result,
    .busStartAddr, .memStartAddr, .blockWords, .burstSize,
    .requestDmaIn, .requestDmaOut
  );

  dmaController #(.lineStride(lineStride)) dmaController_i (
    .clock, .rstN, .busStartAddr, .memStartAddr, .blockWords, .burstSize,
    .requestDmaIn, .requestDmaOut, .transactionGranted, .busErrorIn, .busyIn,
    .endTransactionReg, .dataValidReg, .ramReadData,
    .dmaBusy, .busError, .ramWriteEnable, .ramAddress,
    .requestTransaction, .beginTransactionOut, .readNotWriteOut, .endTransactionOut,
    .dataValidOut, .byteEnablesOut, .burstSizeOut, .addressDataOut
  );

  // one address serves both ports, a transfer only reads or only writes
  dualPortRam #(.memWords(memWords)) dualPortRam_i (
    .clock,
    .writeEnable (ramWriteEnable),
    .writeAddress(ramAddress),
    .writeData   (addressDataReg),
    .readAddress (ramAddress),
    .readData    (ramReadData)
  );

endmodule

`default_nettype wire

// ==== tbRamDmaCi.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbRamDmaCi;

  localparam int numLoops      = 4;
  localparam int maxBlock      = 40;
  localparam int wordCycles    = 8;  // gaps, busy stalls and polling per word
  localparam int burstOverhead = 8 + int'(dmaPkg::endWriteTransaction) + 1;
  localparam int numTransfers  = 2 * numLoops + 3;
  localparam longint timeLimit = longint'(numTransfers) * maxBlock *
                                 (wordCycles + burstOverhead) * 40 + 100000;

  logic clock;
  logic rstN;
  logic start;
  dmaPkg::ciId ciN;
  dmaPkg::busWord valueA;
  dmaPkg::busWord valueB;
  logic done;
  dmaPkg::busWord result;
  logic requestTransaction;
  logic transactionGranted = 1'b0;
  logic endTransactionIn = 1'b0;
  logic dataValidIn = 1'b0;
  logic busErrorIn = 1'b0;
  logic busyIn = 1'b0;
  dmaPkg::busWord addressDataIn = '0;
  logic beginTransactionOut;
  logic readNotWriteOut;
  logic endTransactionOut;
  logic dataValidOut;
  logic [3:0] byteEnablesOut;
  dmaPkg::burstLen burstSizeOut;
  dmaPkg::busWord addressDataOut;

  logic [31:0] rngState = 32'he73dadea;
  dmaPkg::busWord busMem [dmaPkg::busWord];  // bus slave storage
  dmaPkg::busWord refMem [512];              // mirror of the DUT memory
  dmaPkg::busWord hdrAddrQ [$];
  logic hdrReadQ [$];
  dmaPkg::burstLen hdrBurstQ [$];
  dmaPkg::busWord writeQ [$];
  dmaPkg::memAddr refIdx;
  logic errorMode = 1'b0;
  int slaveMode = 0;  // 0 none, 1 read burst, 2 write burst

  // configuration as the model sees it
  dmaPkg::busWord busAddrM;
  dmaPkg::memAddr memAddrM;
  dmaPkg::blockSize blockM;
  dmaPkg::burstLen burstM;

  ramDmaCi #(.customIdDma(8'd0), .lineStride(32'd640), .memWords(512)) dut_i (.*);

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkWord(input string name, input dmaPkg::busWord got,
                           input dmaPkg::busWord exp);
    if (got !== exp)
      failRun($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic checkBurst(input string name, input dmaPkg::burstLen got,
                            input dmaPkg::burstLen exp);
    if (got !== exp)
      failRun($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic checkAddr(input string name, input dmaPkg::memAddr got,
                           input dmaPkg::memAddr exp);
    if (got !== exp)
      failRun($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp)
      failRun($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic ciWrite(input dmaPkg::ciCommand cmd, input dmaPkg::busWord data);
    @(posedge clock);
    start  <= 1'b1;
    valueA <= dmaPkg::busWord'(cmd) << 9;
    valueB <= data;
    @(posedge clock);
    checkBit("done", done, 1'b1);  // same cycle for writes
    start <= 1'b0;
  endtask

  task automatic ciRead(input dmaPkg::ciSelect sel, output dmaPkg::busWord r);
    @(posedge clock);
    start  <= 1'b1;
    valueA <= dmaPkg::busWord'(sel) << 10;
    @(posedge clock);
    checkBit("done", done, 1'b0);
    checkWord("result", result, '0);
    start <= 1'b0;
    @(posedge clock);
    checkBit("done", done, 1'b1);
    r = result;
  endtask

  task automatic configure();
    busAddrM = nextRandom();
    memAddrM = dmaPkg::memAddr'(nextRandom());
    blockM   = dmaPkg::blockSize'(nextRandom() % maxBlock + 1);
    burstM   = dmaPkg::burstLen'(nextRandom() % 8);
    ciWrite(dmaPkg::cmdSetBusAddr, busAddrM);
    ciWrite(dmaPkg::cmdSetMemAddr, dmaPkg::busWord'(memAddrM));
    ciWrite(dmaPkg::cmdSetBlockSize, dmaPkg::busWord'(blockM));
    ciWrite(dmaPkg::cmdSetBurstSize, dmaPkg::busWord'(burstM));
  endtask

  task automatic readBackAll();
    dmaPkg::busWord r;
    ciRead(dmaPkg::selBusAddr, r);
    checkWord("busStartAddr", r, busAddrM);
    ciRead(dmaPkg::selMemAddr, r);
    checkAddr("memStartAddr", dmaPkg::memAddr'(r), memAddrM);
    ciRead(dmaPkg::selBlockSize, r);
    checkWord("blockWords", r, dmaPkg::busWord'(blockM));
    ciRead(dmaPkg::selBurstSize, r);
    checkBurst("burstSize", dmaPkg::burstLen'(r), burstM);
  endtask

  // expected burst headers from the burst rule
  task automatic pushHeaders(input logic toMem);
    int remaining;
    int chunk;
    dmaPkg::busWord addr;
    remaining = blockM;
    addr = busAddrM;
    while (remaining > 0)
    begin
      chunk = (remaining > burstM + 1) ? burstM + 1 : remaining;
      hdrAddrQ.push_back({addr[31:2], 2'b00});
      hdrReadQ.push_back(toMem);
      hdrBurstQ.push_back(dmaPkg::burstLen'(chunk - 1));
      remaining = remaining - chunk;
      addr = addr + 32'd640;
    end
  endtask

  task automatic waitIdle();
    dmaPkg::busWord r;
    do
      ciRead(dmaPkg::selStatus, r);
    while (r[0]);
  endtask

  // second start is sent while busy when ignoreStart is set
  task automatic runTransfer(input logic toMem, input logic ignoreStart);
    dmaPkg::busWord r;
    if (!errorMode)
      pushHeaders(toMem);
    refIdx = memAddrM;
    if (!toMem && !errorMode)
      for (int i = 0; i < blockM; i++)
        writeQ.push_back(refMem[dmaPkg::memAddr'(memAddrM + i)]);
    ciWrite(dmaPkg::cmdStartDma, toMem ? 32'd1 : 32'd2);
    ciRead(dmaPkg::selStatus, r);
    checkWord("status", r, 32'd1);  // busy, error cleared
    if (ignoreStart)
      ciWrite(dmaPkg::cmdStartDma, toMem ? 32'd2 : 32'd1);
    waitIdle();
    ciRead(dmaPkg::selStatus, r);
    checkWord("status", r, errorMode ? 32'd2 : 32'd0);
    if (slaveMode != 0)
      failRun("bus burst still open after the transfer ended");
    if (!errorMode && (hdrAddrQ.size() != 0 || writeQ.size() != 0))
      failRun("transfer ended before all bursts or words were seen");
  endtask

  // bus slave
  always @(posedge clock)
  begin
    static int wordsToGo = 0;
    static int wordCount = 0;
    static dmaPkg::burstLen burstExp = '0;
    static dmaPkg::busWord busAddr = '0;
    static int grantDelay = 0;
    dmaPkg::busWord data;
    dataValidIn      <= 1'b0;
    endTransactionIn <= 1'b0;
    busErrorIn       <= 1'b0;
    busyIn           <= 1'b0;
    if (requestTransaction && !transactionGranted)
    begin
      if (grantDelay == 0)
      begin
        transactionGranted <= 1'b1;
        grantDelay = nextRandom() % 5;
      end
      else
        grantDelay--;
    end
    else
      transactionGranted <= 1'b0;
    if (endTransactionOut && slaveMode != 2)
      failRun("endTransactionOut outside a write burst");
    if (beginTransactionOut)
    begin
      if (slaveMode != 0)
        failRun("burst header before the previous burst ended");
      if (!errorMode)
      begin
        if (hdrAddrQ.size() == 0)
          failRun("unexpected burst header");
        checkWord("addressDataOut", addressDataOut, hdrAddrQ.pop_front());
        checkBit("readNotWriteOut", readNotWriteOut, hdrReadQ.pop_front());
        checkBurst("burstSizeOut", burstSizeOut, hdrBurstQ.pop_front());
      end
      checkWord("byteEnablesOut", dmaPkg::busWord'(byteEnablesOut), 32'hF);
      busErrorIn <= errorMode;
      wordsToGo = burstSizeOut + 1;
      burstExp = burstSizeOut;
      busAddr = addressDataOut;
      wordCount = 0;
      slaveMode = readNotWriteOut ? 1 : 2;
    end
    else if (slaveMode == 1 && nextRandom() % 4 != 0)
    begin
      data = busMem.exists(busAddr) ? busMem[busAddr] : nextRandom();
      dataValidIn      <= 1'b1;
      addressDataIn    <= data;
      endTransactionIn <= (wordsToGo == 1);  // end comes with the last word
      busMem[busAddr] = data;
      if (!errorMode)
        refMem[refIdx] = data;
      refIdx = refIdx + 9'd1;
      busAddr = busAddr + 32'd4;
      wordsToGo--;
      if (wordsToGo == 0)
        slaveMode = 0;
    end
    else if (slaveMode == 2)
    begin
      busyIn <= !errorMode && (nextRandom() % 3 == 0);
      if (dataValidOut && !busyIn)
      begin
        busMem[busAddr] = addressDataOut;
        busAddr = busAddr + 32'd4;
        wordCount++;
        if (!errorMode)
        begin
          if (writeQ.size() == 0)
            failRun("write word beyond the end of the block");
          checkWord("addressDataOut", addressDataOut, writeQ.pop_front());
        end
      end
      if (endTransactionOut)
      begin
        if (!errorMode)
          checkBurst("words in burst", dmaPkg::burstLen'(wordCount - 1), burstExp);
        busyIn <= 1'b0;
        slaveMode = 0;
      end
    end
  end

  initial
  begin
    #(timeLimit);
    failRun("watchdog timeout, the DUT stopped finishing transfers");
  end

  initial
  begin
    dmaPkg::busWord r;
    rstN   <= 1'b0;
    start  <= 1'b0;
    ciN    <= '0;
    valueA <= '0;
    valueB <= '0;
    repeat (8) @(posedge clock);
    rstN <= 1'b1;
    @(posedge clock);
    checkBit("requestTransaction", requestTransaction, 1'b0);
    checkBit("beginTransactionOut", beginTransactionOut, 1'b0);
    checkBit("endTransactionOut", endTransactionOut, 1'b0);
    checkBit("dataValidOut", dataValidOut, 1'b0);
    checkWord("byteEnablesOut", dmaPkg::busWord'(byteEnablesOut), '0);
    checkBurst("burstSizeOut", burstSizeOut, '0);
    checkBit("done", done, 1'b0);
    busAddrM = '0;
    memAddrM = '0;
    blockM = '0;
    burstM = '0;
    readBackAll();
    ciRead(dmaPkg::selStatus, r);
    checkWord("status", r, '0);

    for (int loop = 0; loop < numLoops; loop++)
    begin
      configure();
      readBackAll();
      runTransfer(1'b1, loop == 1);
      readBackAll();  // ignored start left the registers alone
      busAddrM = nextRandom();
      ciWrite(dmaPkg::cmdSetBusAddr, busAddrM);
      runTransfer(1'b0, loop == 2);
    end

    // bus errors in a read and in a write burst
    errorMode = 1'b1;
    configure();
    runTransfer(1'b1, 1'b0);
    runTransfer(1'b0, 1'b0);
    errorMode = 1'b0;
    configure();
    runTransfer(1'b1, 1'b0);

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
dmaPkg.sv
dualPortRam.sv
ciRegisters.sv
dmaController.sv
ramDmaCi.sv
tbRamDmaCi.sv

// ==== run.sh ====
#!/bin/bash
# builds and runs the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f --top-module tbRamDmaCi -o simRamDmaCi

./obj_dir/simRamDmaCi > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
exit 0
